//--- verilog/pixwb_pkg.sv
// Shared widths, constants and types for the pixel write-back pipeline.
// RTL and testbench refer to these by scoped names (pixwb_pkg::name).
// Pixel addresses count 16-bit units, word addresses count 64-bit words.

package pixwb_pkg;

	// Destination pixel address width, in 16-bit units.
	localparam int PIX_ADR_W = 24;

	// Four RGB565 pixels fit in one 64-bit memory word.
	localparam int PIX_PER_WORD = 4;

	// Word address drops the lane bits of the pixel address.
	localparam int WORD_ADR_W = PIX_ADR_W - $clog2(PIX_PER_WORD);

	// Entries in the output FIFO.
	localparam int FIFO_DEPTH = 8;

	// RGB565 colour. Red 15:11, green 10:5, blue 4:0.
	typedef logic [15:0] color_t;

	typedef logic [PIX_ADR_W-1:0] pix_adr_t;

	typedef logic [WORD_ADR_W-1:0] word_adr_t;

	// Brightness 0..63, where 63 leaves the colour unchanged.
	typedef logic [5:0] bright_t;

	// Byte enables, two per pixel lane.
	typedef logic [7:0] sel_t;

	typedef logic [63:0] word_t;

	// Burst assembler states.
	typedef enum logic [1:0] {
		EMPTY,
		FILLING,
		SENDING,
		FLUSH_WAIT
	} asm_state_t;

endpackage

//--- verilog/pixel_decay.sv
// Decay stage of the pixel write-back pipeline.
// Scales each RGB565 pixel by a programmable brightness and drops pixels
// that match the chroma key. One output register with stb/ack on both sides.

`timescale 1ns/1ps

module pixel_decay (
	input  logic               sys_clk,
	input  logic               sys_rst,

	input  pixwb_pkg::bright_t brightness_i,
	input  logic               chroma_key_en_i,
	input  pixwb_pkg::color_t  chroma_key_i,

	input  logic               pix_stb_i,
	output logic               pix_ack_o,
	input  pixwb_pkg::color_t  pix_color_i,
	input  pixwb_pkg::pix_adr_t pix_adr_i,

	output logic               out_stb_o,
	input  logic               out_ack_i,
	output pixwb_pkg::color_t  out_color_o,
	output pixwb_pkg::pix_adr_t out_adr_o,

	output logic               busy_o
);

	logic [6:0] scale;
	logic [10:0] r_prod;
	logic [11:0] g_prod;
	logic [10:0] b_prod;
	pixwb_pkg::color_t decayed;
	logic keyed;
	logic accept;

	// Multiply by brightness+1, then drop six bits.
	assign scale = {1'b0, brightness_i} + 7'd1;
	assign r_prod = pix_color_i[15:11] * scale;
	assign g_prod = pix_color_i[10:5] * scale;
	assign b_prod = pix_color_i[4:0] * scale;
	assign decayed = {r_prod[10:6], g_prod[11:6], b_prod[10:6]};

	// Key compares the colour before scaling.
	assign keyed = chroma_key_en_i && (pix_color_i == chroma_key_i);

	// Room when the register is empty or being drained.
	assign pix_ack_o = ~out_stb_o | out_ack_i;
	assign accept = pix_stb_i & pix_ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			out_stb_o <= 1'b0;
		end else if (accept && !keyed) begin
			out_stb_o <= 1'b1;
		end else if (out_ack_i) begin
			out_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept && !keyed) begin
			out_color_o <= decayed;
			out_adr_o <= pix_adr_i;
		end
	end

	assign busy_o = out_stb_o;

	// A stalled pixel holds its data until taken.
	a_out_stable: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		out_stb_o && !out_ack_i |=>
			out_stb_o && $stable(out_color_o) && $stable(out_adr_o)
	);

endmodule

//--- verilog/pixel_fifo.sv
// Output FIFO between the decay stage and the burst assembler.
// Circular buffer of colour and address pairs with stb/ack on both sides.
// Data written is visible at the output on the following cycle.

`timescale 1ns/1ps

module pixel_fifo (
	input  logic                sys_clk,
	input  logic                sys_rst,

	input  logic                in_stb_i,
	output logic                in_ack_o,
	input  pixwb_pkg::color_t   in_color_i,
	input  pixwb_pkg::pix_adr_t in_adr_i,

	output logic                out_stb_o,
	input  logic                out_ack_i,
	output pixwb_pkg::color_t   out_color_o,
	output pixwb_pkg::pix_adr_t out_adr_o,

	output logic                empty_o
);

	pixwb_pkg::color_t color_mem [pixwb_pkg::FIFO_DEPTH];
	pixwb_pkg::pix_adr_t adr_mem [pixwb_pkg::FIFO_DEPTH];

	logic [$clog2(pixwb_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(pixwb_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(pixwb_pkg::FIFO_DEPTH):0] count;
	logic wr_en;
	logic rd_en;

	assign in_ack_o = (count != pixwb_pkg::FIFO_DEPTH);
	assign out_stb_o = (count != 0);
	assign empty_o = (count == 0);

	assign wr_en = in_stb_i & in_ack_o;
	assign rd_en = out_stb_o & out_ack_i;

	assign out_color_o = color_mem[rd_ptr];
	assign out_adr_o = adr_mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			color_mem[wr_ptr] <= in_color_i;
			adr_mem[wr_ptr] <= in_adr_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				if (wr_ptr == pixwb_pkg::FIFO_DEPTH - 1)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				if (rd_ptr == pixwb_pkg::FIFO_DEPTH - 1)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// An underflow would wrap the count above the depth.
	a_count_bound: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		count <= pixwb_pkg::FIFO_DEPTH
	);

	// Pointer distance agrees with the fill level.
	a_ptr_count: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		wr_ptr - rd_ptr == count[$clog2(pixwb_pkg::FIFO_DEPTH)-1:0]
	);

endmodule

//--- verilog/burst_assembler.sv
// Burst assembler at the end of the pixel write-back pipeline.
// Merges pixels of the same 64-bit word into one write with byte enables.
// A flush writes out a partial word once the decay stage and FIFO are idle.

`timescale 1ns/1ps

module burst_assembler (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  logic                 flush_i,
	input  logic                 decay_busy_i,
	input  logic                 fifo_empty_i,

	input  logic                 pix_stb_i,
	output logic                 pix_ack_o,
	input  pixwb_pkg::color_t    pix_color_i,
	input  pixwb_pkg::pix_adr_t  pix_adr_i,

	output logic                 burst_stb_o,
	input  logic                 burst_ack_i,
	output pixwb_pkg::word_adr_t burst_adr_o,
	output pixwb_pkg::sel_t      burst_sel_o,
	output pixwb_pkg::word_t     burst_dat_o,

	output logic                 busy_o
);

	pixwb_pkg::asm_state_t state;
	pixwb_pkg::asm_state_t next_state;

	pixwb_pkg::word_adr_t word_adr_q;
	pixwb_pkg::sel_t sel_q;
	pixwb_pkg::word_t dat_q;
	logic flush_pending_q;

	pixwb_pkg::word_adr_t pix_word;
	logic [$clog2(pixwb_pkg::PIX_PER_WORD)-1:0] pix_lane;
	pixwb_pkg::sel_t merged_sel;
	pixwb_pkg::word_t merged_dat;
	logic can_accept;
	logic hit;
	logic accept;
	logic upstream_idle;
	logic flush_done;

	assign pix_word = pix_adr_i[pixwb_pkg::PIX_ADR_W-1:$clog2(pixwb_pkg::PIX_PER_WORD)];
	assign pix_lane = pix_adr_i[$clog2(pixwb_pkg::PIX_PER_WORD)-1:0];

	// Nothing held counts as a hit, so the pixel opens a new word.
	assign hit = (sel_q == '0) || (pix_word == word_adr_q);
	assign can_accept = (state == pixwb_pkg::EMPTY) || (state == pixwb_pkg::FILLING)
		|| (state == pixwb_pkg::FLUSH_WAIT);
	assign pix_ack_o = can_accept & hit;
	assign accept = pix_stb_i & pix_ack_o;

	assign upstream_idle = !decay_busy_i && fifo_empty_i;

	// Later pixel in a lane overwrites the earlier one.
	always_comb begin
		merged_dat = (sel_q == '0) ? '0 : dat_q;
		merged_dat[16*pix_lane +: 16] = pix_color_i;
		merged_sel = sel_q | (8'b11 << (2*pix_lane));
	end

	always_comb begin
		next_state = state;
		flush_done = 1'b0;
		case (state)
			pixwb_pkg::EMPTY, pixwb_pkg::FILLING: begin
				if (pix_stb_i && !hit)
					next_state = pixwb_pkg::SENDING;
				else if (flush_i || flush_pending_q)
					next_state = pixwb_pkg::FLUSH_WAIT;
				else if (accept)
					next_state = pixwb_pkg::FILLING;
			end
			pixwb_pkg::FLUSH_WAIT: begin
				if (pix_stb_i && !hit) begin
					next_state = pixwb_pkg::SENDING;
				end else if (upstream_idle && !accept) begin
					flush_done = 1'b1;
					if (sel_q != '0)
						next_state = pixwb_pkg::SENDING;
					else
						next_state = pixwb_pkg::EMPTY;
				end
			end
			pixwb_pkg::SENDING: begin
				if (burst_ack_i) begin
					if (flush_i || flush_pending_q)
						next_state = pixwb_pkg::FLUSH_WAIT;
					else
						next_state = pixwb_pkg::EMPTY;
				end
			end
			default: next_state = pixwb_pkg::EMPTY;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= pixwb_pkg::EMPTY;
			sel_q <= '0;
			flush_pending_q <= 1'b0;
		end else begin
			state <= next_state;
			if (flush_i)
				flush_pending_q <= 1'b1;
			else if (flush_done)
				flush_pending_q <= 1'b0;
			if (accept)
				sel_q <= merged_sel;
			else if (burst_stb_o && burst_ack_i)
				sel_q <= '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			word_adr_q <= pix_word;
			dat_q <= merged_dat;
		end
	end

	assign burst_stb_o = (state == pixwb_pkg::SENDING);
	assign burst_adr_o = word_adr_q;
	assign burst_sel_o = sel_q;
	assign burst_dat_o = dat_q;

	assign busy_o = (state != pixwb_pkg::EMPTY) || flush_pending_q || flush_i
		|| !upstream_idle;

	a_burst_stable: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		burst_stb_o && !burst_ack_i |=> burst_stb_o && $stable(burst_adr_o)
			&& $stable(burst_sel_o) && $stable(burst_dat_o)
	);

	// Every write carries at least one pixel lane.
	a_sel_nonzero: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		burst_stb_o |-> burst_sel_o != '0
	);

endmodule

//--- verilog/pixel_writeback.sv
// Top level of the pixel write-back pipeline.
// Decay stage, output FIFO and burst assembler in a chain of stb/ack links.
// Writes leave as 64-bit words with byte enables on the burst port.

`timescale 1ns/1ps

module pixel_writeback (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  pixwb_pkg::bright_t   brightness_i,
	input  logic                 chroma_key_en_i,
	input  pixwb_pkg::color_t    chroma_key_i,
	input  logic                 flush_i,

	input  logic                 pix_stb_i,
	output logic                 pix_ack_o,
	input  pixwb_pkg::color_t    pix_color_i,
	input  pixwb_pkg::pix_adr_t  pix_adr_i,

	output logic                 burst_stb_o,
	input  logic                 burst_ack_i,
	output pixwb_pkg::word_adr_t burst_adr_o,
	output pixwb_pkg::sel_t      burst_sel_o,
	output pixwb_pkg::word_t     burst_dat_o,

	output logic                 busy_o
);

	// Decay to FIFO.
	logic decay_stb;
	logic decay_ack;
	pixwb_pkg::color_t decay_color;
	pixwb_pkg::pix_adr_t decay_adr;
	logic decay_busy;

	// FIFO to assembler.
	logic fifo_stb;
	logic fifo_ack;
	pixwb_pkg::color_t fifo_color;
	pixwb_pkg::pix_adr_t fifo_adr;
	logic fifo_empty;

	pixel_decay decay_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.brightness_i(brightness_i),
		.chroma_key_en_i(chroma_key_en_i),
		.chroma_key_i(chroma_key_i),
		.pix_stb_i(pix_stb_i),
		.pix_ack_o(pix_ack_o),
		.pix_color_i(pix_color_i),
		.pix_adr_i(pix_adr_i),
		.out_stb_o(decay_stb),
		.out_ack_i(decay_ack),
		.out_color_o(decay_color),
		.out_adr_o(decay_adr),
		.busy_o(decay_busy)
	);

	pixel_fifo fifo_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.in_stb_i(decay_stb),
		.in_ack_o(decay_ack),
		.in_color_i(decay_color),
		.in_adr_i(decay_adr),
		.out_stb_o(fifo_stb),
		.out_ack_i(fifo_ack),
		.out_color_o(fifo_color),
		.out_adr_o(fifo_adr),
		.empty_o(fifo_empty)
	);

	burst_assembler burst_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.decay_busy_i(decay_busy),
		.fifo_empty_i(fifo_empty),
		.pix_stb_i(fifo_stb),
		.pix_ack_o(fifo_ack),
		.pix_color_i(fifo_color),
		.pix_adr_i(fifo_adr),
		.burst_stb_o(burst_stb_o),
		.burst_ack_i(burst_ack_i),
		.burst_adr_o(burst_adr_o),
		.burst_sel_o(burst_sel_o),
		.burst_dat_o(burst_dat_o),
		.busy_o(busy_o)
	);

endmodule

//--- tb/pixwb_model.svh
// Reference model for the pixel write-back testbench, included inside the
// testbench module. Applies decay and chroma keying, merges pixels into
// words and queues every closed word as an expected write.

`ifndef PIXWB_MODEL_SVH
`define PIXWB_MODEL_SVH

// Word under assembly in the model.
pixwb_pkg::word_adr_t m_adr = '0;
pixwb_pkg::sel_t m_sel = '0;
pixwb_pkg::word_t m_dat = '0;

// Expected writes, oldest first.
pixwb_pkg::word_adr_t exp_adr_q[$];
pixwb_pkg::sel_t exp_sel_q[$];
pixwb_pkg::word_t exp_dat_q[$];

// Each channel times (brightness + 1), then divided by 64.
function automatic pixwb_pkg::color_t decay_ref(input pixwb_pkg::color_t c,
		input pixwb_pkg::bright_t b);
	int k;
	int r;
	int g;
	int bl;
	k = b + 1;
	r = (c[15:11] * k) / 64;
	g = (c[10:5] * k) / 64;
	bl = (c[4:0] * k) / 64;
	return {r[4:0], g[5:0], bl[4:0]};
endfunction

// Full byte mask from the sel bits.
function automatic pixwb_pkg::word_t byte_mask(input pixwb_pkg::sel_t s);
	pixwb_pkg::word_t m;
	for (int i = 0; i < 8; i++)
		m[8*i +: 8] = {8{s[i]}};
	return m;
endfunction

function automatic void close_word();
	if (m_sel != '0) begin
		exp_adr_q.push_back(m_adr);
		exp_sel_q.push_back(m_sel);
		exp_dat_q.push_back(m_dat);
	end
	m_sel = '0;
	m_dat = '0;
endfunction

// Keyed pixels vanish. A new word address closes the held word first.
function automatic void model_pixel(input pixwb_pkg::pix_adr_t adr,
		input pixwb_pkg::color_t c, input pixwb_pkg::bright_t b,
		input logic key_en, input pixwb_pkg::color_t key);
	pixwb_pkg::word_adr_t w;
	int lane;
	w = pixwb_pkg::word_adr_t'(adr / pixwb_pkg::PIX_PER_WORD);
	lane = adr % pixwb_pkg::PIX_PER_WORD;
	if (!(key_en && c == key)) begin
		if (m_sel != '0 && w != m_adr)
			close_word();
		m_adr = w;
		m_dat[16*lane +: 16] = decay_ref(c, b);
		m_sel = m_sel | (pixwb_pkg::sel_t'(3) << (2*lane));
	end
endfunction

`endif

//--- tb/tb_pixel_writeback.sv
// Testbench for the pixel write-back pipeline.
// Drives pixel streams and flushes, adds random back-pressure on the burst
// port and checks every write against the included reference model.

`timescale 1ns/1ps

module tb_pixel_writeback;

	localparam int CLK_PERIOD = 4;
	localparam int SEED = 32'h65932a63;
	localparam int N_BRIGHT = 8;
	localparam int N_KEY = 8;
	localparam int N_MERGE = 12;
	localparam int N_RANDOM = 200;
	localparam int N_FLUSH = 3;
	localparam int N_PIXELS = 3 * N_BRIGHT + 2 * N_KEY + N_MERGE + N_RANDOM + N_FLUSH;
	localparam int TIMEOUT_CYCLES = 20 * N_PIXELS + 400;

	logic sys_clk = 1'b0;
	logic sys_rst;
	pixwb_pkg::bright_t brightness_i;
	logic chroma_key_en_i;
	pixwb_pkg::color_t chroma_key_i;
	logic flush_i;
	logic pix_stb_i;
	logic pix_ack_o;
	pixwb_pkg::color_t pix_color_i;
	pixwb_pkg::pix_adr_t pix_adr_i;
	logic burst_stb_o;
	logic burst_ack_i;
	pixwb_pkg::word_adr_t burst_adr_o;
	pixwb_pkg::sel_t burst_sel_o;
	pixwb_pkg::word_t burst_dat_o;
	logic busy_o;
	logic bp_en = 1'b0;
	int writes_seen = 0;

	`include "pixwb_model.svh"

	pixel_writeback dut_i (.*);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// Random burst back-pressure when enabled for the phase.
	always begin
		@(posedge sys_clk);
		#1;
		burst_ack_i = bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
	end

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	// Holds the pixel until the DUT takes it.
	task automatic send_pixel(input pixwb_pkg::pix_adr_t adr, input pixwb_pkg::color_t c);
		pix_stb_i = 1'b1;
		pix_adr_i = adr;
		pix_color_i = c;
		@(posedge sys_clk);
		while (!pix_ack_o)
			@(posedge sys_clk);
		#1;
		pix_stb_i = 1'b0;
		model_pixel(adr, c, brightness_i, chroma_key_en_i, chroma_key_i);
	endtask

	task automatic issue_flush();
		flush_i = 1'b1;
		@(posedge sys_clk);
		#1;
		flush_i = 1'b0;
		close_word();
		@(posedge sys_clk);
		while (busy_o)
			@(posedge sys_clk);
		#1;
		assert (exp_adr_q.size() == 0) else begin
			$display("Flush ended with %0d expected writes missing", exp_adr_q.size());
			abort_run();
		end
	endtask

	always @(posedge sys_clk) begin : compare_writes
		pixwb_pkg::word_adr_t e_adr;
		pixwb_pkg::sel_t e_sel;
		pixwb_pkg::word_t e_dat;
		if (!sys_rst && burst_stb_o && burst_ack_i) begin
			assert (exp_adr_q.size() != 0) else begin
				$display("Unexpected write to word %h at %0t", burst_adr_o, $time);
				abort_run();
			end
			e_adr = exp_adr_q.pop_front();
			e_sel = exp_sel_q.pop_front();
			e_dat = exp_dat_q.pop_front();
			assert (burst_adr_o == e_adr) else begin
				$display("Fail %0t burst_adr_o got %h expected %h", $time, burst_adr_o, e_adr);
				abort_run();
			end
			assert (burst_sel_o == e_sel) else begin
				$display("Fail %0t burst_sel_o got %h expected %h", $time, burst_sel_o, e_sel);
				abort_run();
			end
			assert ((burst_dat_o & byte_mask(e_sel)) == (e_dat & byte_mask(e_sel))) else begin
				$display("Fail %0t burst_dat_o got %h expected %h", $time, burst_dat_o, e_dat);
				abort_run();
			end
			writes_seen = writes_seen + 1;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$fatal(1, "Timeout.");
	end

	initial begin : main_sequence
		pixwb_pkg::pix_adr_t adr;
		pixwb_pkg::color_t key_pix [N_KEY];
		pixwb_pkg::color_t palette [4];
		int merge_lane [N_MERGE] = '{0, 1, 2, 3, 1, 2, 3, 3, 0, 2, 2, 2};
		int count_before;
		int gap;
		void'($urandom(SEED));
		sys_rst = 1'b1;
		brightness_i = 6'd63;
		chroma_key_en_i = 1'b0;
		chroma_key_i = 16'hf81f;
		flush_i = 1'b0;
		pix_stb_i = 1'b0;
		pix_color_i = '0;
		pix_adr_i = '0;
		burst_ack_i = 1'b0;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		assert (!burst_stb_o && !busy_o && pix_ack_o) else begin
			$display("Outputs not idle after reset");
			abort_run();
		end

		// Brightness 63 and 0 and then a random level. One word per pixel.
		for (int lvl = 0; lvl < 3; lvl++) begin
			brightness_i = (lvl == 0) ? 6'd63 : (lvl == 1) ? 6'd0
				: pixwb_pkg::bright_t'($urandom_range(1, 62));
			for (int i = 0; i < N_BRIGHT; i++) begin
				adr = {pixwb_pkg::word_adr_t'(256 + 16 * lvl + i), 2'($urandom_range(0, 3))};
				send_pixel(adr, pixwb_pkg::color_t'($urandom));
			end
			issue_flush();
		end

		// Same pixels keyed and then unkeyed. Odd lanes carry the key.
		for (int i = 0; i < N_KEY; i++)
			key_pix[i] = (i % 2 == 1) ? chroma_key_i : pixwb_pkg::color_t'($urandom);
		for (int run = 0; run < 2; run++) begin
			chroma_key_en_i = (run == 0);
			for (int i = 0; i < N_KEY; i++)
				send_pixel({pixwb_pkg::word_adr_t'(512 + i / 4), 2'(i % 4)}, key_pix[i]);
			issue_flush();
		end

		// Three words from sequential and repeated lanes.
		chroma_key_en_i = 1'b0;
		count_before = writes_seen;
		for (int i = 0; i < N_MERGE; i++) begin
			adr = {pixwb_pkg::word_adr_t'(768 + (i >= 6) + (i >= 9)), 2'(merge_lane[i])};
			send_pixel(adr, pixwb_pkg::color_t'($urandom));
		end
		issue_flush();
		assert (writes_seen == count_before + 3) else begin
			$display("Merge phase gave %0d writes instead of 3", writes_seen - count_before);
			abort_run();
		end

		// Random stream under back-pressure with keys from a small palette.
		for (int i = 0; i < 4; i++)
			palette[i] = pixwb_pkg::color_t'($urandom);
		bp_en = 1'b1;
		brightness_i = pixwb_pkg::bright_t'($urandom);
		chroma_key_en_i = 1'b1;
		chroma_key_i = palette[0];
		adr = pixwb_pkg::pix_adr_t'($urandom);
		for (int i = 0; i < N_RANDOM; i++) begin
			case ($urandom_range(0, 7))
				0: adr = pixwb_pkg::pix_adr_t'($urandom);
				1: adr = adr;
				default: adr = adr + 1'b1;
			endcase
			send_pixel(adr, ($urandom_range(0, 3) == 0) ? palette[$urandom_range(0, 3)]
				: pixwb_pkg::color_t'($urandom));
			gap = $urandom_range(0, 2);
			if (gap != 0) begin
				repeat (gap) @(posedge sys_clk);
				#1;
			end
		end
		issue_flush();
		bp_en = 1'b0;

		// Partial word flush and then a flush with nothing held.
		chroma_key_en_i = 1'b0;
		count_before = writes_seen;
		for (int i = 0; i < N_FLUSH; i++)
			send_pixel({pixwb_pkg::word_adr_t'(1024), 2'(i)}, pixwb_pkg::color_t'($urandom));
		issue_flush();
		assert (writes_seen == count_before + 1) else begin
			$display("Partial word flush did not give exactly one write");
			abort_run();
		end
		count_before = writes_seen;
		issue_flush();
		assert (writes_seen == count_before) else begin
			$display("Flush with no word held produced a write");
			abort_run();
		end

		if (exp_adr_q.size() == 0 && m_sel == '0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("%0d expected writes never arrived", exp_adr_q.size());
			$display("TB FAILED");
			$fatal(1, "Writes missing at end of run.");
		end
	end

endmodule

//--- build.f
+incdir+tb
verilog/pixwb_pkg.sv
verilog/pixel_decay.sv
verilog/pixel_fifo.sv
verilog/burst_assembler.sv
verilog/pixel_writeback.sv
tb/tb_pixel_writeback.sv
